// ==== dv/cell_pair_assertions.sv ====
// Concurrent checks on the pair unit handshakes
// Result hold under stall, read issue and reset state

`timescale 1ns/1ps

module cell_pair_assertions (
	input logic                   clk,
	input logic                   rst,
	input logic                   req_valid,
	input logic                   req_ready,
	input md_ctrl_pkg::cache_rd_t rd_a,
	input md_ctrl_pkg::pair_res_t res,
	input logic                   res_valid,
	input logic                   res_ready
);

	// Failed assertions so far
	int unsigned fail_cnt = 0;

	// Held result keeps valid and value until taken
	a_res_stable: assert property (@(posedge clk) disable iff (rst)
		(res_valid && !res_ready) |=> (res_valid && $stable(res)))
	else
	begin
		$error("res changed or dropped while stalled");
		fail_cnt = fail_cnt + 1;
	end

	// Accepted request reads the caches and shows a result two edges later
	a_issue: assert property (@(posedge clk) disable iff (rst)
		(req_valid && req_ready) |-> rd_a.en ##2 res_valid)
	else
	begin
		$error("accepted request did not give a result two edges later");
		fail_cnt = fail_cnt + 1;
	end

	// No result straight out of reset
	a_reset: assert property (@(posedge clk) rst |=> !res_valid)
	else
	begin
		$error("res_valid high after reset");
		fail_cnt = fail_cnt + 1;
	end

endmodule

// ==== dv/cell_pair_input.txt ====
# B dst x y z : broadcast particle, all hex | E : end of motion update | S n : res_ready max gap
# R addr_a addr_b : request, hex | X ax ay az bx by bz dist2 : expected result, hex
# Empty caches after reset
S 0
R 00 00
X 0000 0000 0000 0000 0000 0000 0
# First update, cell A 102, cell B 112, third cell 212
B 102 0010 0020 0030
B 112 0013 0024 002c
B 212 0100 0100 0100
B 102 fff0 0005 0000
B 112 0002 fffd 0001
B 102 0007 0007 0007
E
R 00 00
R 01 01
R 02 02
R 03 01
R 03 03
R 04 02
X 0003 0000 0000 0002 0000 0000 1
X 0010 0020 0030 0013 0024 002c 29
X fff0 0005 0000 0002 fffd 0001 185
X 0007 0007 0007 0013 0024 002c 932
X 0007 0007 0007 0000 0000 0000 93
X 0000 0000 0000 0002 fffd 0001 e
# Second update, reads during it see first-update data
B 102 0001 0002 0003
B 112 0004 0006 0003
R 01 01
R 00 00
X 0010 0020 0030 0013 0024 002c 29
X 0003 0000 0000 0002 0000 0000 1
E
R 01 01
R 00 00
X 0001 0002 0003 0004 0006 0003 19
X 0001 0000 0000 0001 0000 0000 0
# Random result back-pressure
S 3
R 01 00
R 00 01
R 02 02
R 01 01
R 00 00
X 0001 0002 0003 0001 0000 0000 d
X 0001 0000 0000 0004 0006 0003 36
X 0000 0000 0000 0000 0000 0000 0
X 0001 0002 0003 0004 0006 0003 19
X 0001 0000 0000 0001 0000 0000 0
# Overfill cell A with 16 particles, count saturates at 15
S 0
B 102 0001 0000 0000
B 102 0002 0000 0000
B 102 0003 0000 0000
B 102 0004 0000 0000
B 102 0005 0000 0000
B 102 0006 0000 0000
B 102 0007 0000 0000
B 102 0008 0000 0000
B 102 0009 0000 0000
B 102 000a 0000 0000
B 102 000b 0000 0000
B 102 000c 0000 0000
B 102 000d 0000 0000
B 102 000e 0000 0000
B 102 000f 0000 0000
B 102 0010 0000 0000
E
R 00 00
R 0f 00
R 0e 0f
R 01 0f
X 000f 0000 0000 0000 0000 0000 e1
X 000f 0000 0000 0000 0000 0000 e1
X 000e 0000 0000 0000 0000 0000 c4
X 0001 0000 0000 0000 0000 0000 1

// ==== dv/cell_pair_tb.sv ====
// Testbench for the two-cell pair slice
// Reads broadcast, request and expected-result records from the input file

`timescale 1ns/1ps

module cell_pair_tb;

	import md_geom_pkg::*;
	import md_ctrl_pkg::*;

	// Clock edges allowed for any single wait
	localparam int WAIT_LIMIT = 200;

	//////////////////////////////////////////////////////////////////////
	// DUT signals
	//////////////////////////////////////////////////////////////////////

	logic      clk = 1'b0;
	logic      rst;
	logic      mu_enable;
	bcast_t    bcast;
	pair_req_t req;
	logic      req_valid;
	logic      req_ready;
	pair_res_t res;
	logic      res_valid;
	logic      res_ready = 1'b1;
	logic      mu_busy;

	// Results taken off the bus, oldest first
	pair_res_t got_q[$];
	// Result transfers on the coming edge
	logic      took = 1'b0;
	// res_ready gap pattern
	integer    seed = 32'hd3af_0a29;
	int        max_gap = 0;
	int        gap = 0;

	// Fields of one input record
	int                    fd;
	int                    n;
	logic                  done;
	logic [63:0]           tag;
	logic [8*160-1:0]      line;
	logic [11:0]           dst;
	logic [15:0]           fld [6];
	logic [34:0]           exp_d;
	logic [MAX_ADDR_W-1:0] addr_a;
	logic [MAX_ADDR_W-1:0] addr_b;
	int                    gap_in;

	always #5 clk = ~clk;

	cell_pair_top #(
		.DEPTH  (16),
		.CELL_A ('{cx: 4'd1, cy: 4'd0, cz: 4'd2}),
		.CELL_B ('{cx: 4'd1, cy: 4'd1, cz: 4'd2})
	) u_cell_pair_top (
		.clk       (clk),
		.rst       (rst),
		.mu_enable (mu_enable),
		.bcast     (bcast),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.mu_busy   (mu_busy)
	);

	bind pair_dist cell_pair_assertions u_checks (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rd_a      (rd_a),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// Result side
	//////////////////////////////////////////////////////////////////////

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		took = 1'b0;
		if (!rst && res_valid && res_ready)
		begin
			got_q.push_back(res);
			took = 1'b1;
		end
	end

	// Random low gaps after each taken result
	always @(posedge clk)
	begin
		if (gap > 0)
		begin
			res_ready <= 1'b0;
			gap <= gap - 1;
		end
		else
		begin
			res_ready <= 1'b1;
			if (took && max_gap > 0)
				gap <= {$random(seed)} % (max_gap + 1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Failure and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic halt_run();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic stop_with_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		halt_run();
	endtask

	task automatic check_pos(input string what, input pos_t got, input pos_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			halt_run();
		end
	endtask

	task automatic check_dist(input string what, input dist2_t got, input dist2_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			halt_run();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			halt_run();
		end
	endtask

	// Stop on the first failed assertion
	always @(negedge clk)
	begin
		if (u_cell_pair_top.u_pair.u_checks.fail_cnt != 0)
			stop_with_error("a concurrent assertion failed");
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	// One particle on the broadcast bus, update held open
	// Consecutive calls give one particle per cycle
	task automatic send_particle(input cell_id_t to_cell, input pos_t p);
		@(posedge clk);
		mu_enable <= 1'b1;
		bcast <= '{valid: 1'b1, dst: to_cell, pos: p};
		@(negedge clk);
	endtask

	// Take the last particle off the bus on the edge that captures it
	task automatic clear_bus();
		if (bcast.valid)
		begin
			@(posedge clk);
			bcast.valid <= 1'b0;
		end
	endtask

	// Close the update and follow busy through the count write and swap
	task automatic end_update();
		@(posedge clk);
		mu_enable <= 1'b0;
		bcast <= '0;
		@(negedge clk);
		// Busy over the first low edge and the count write
		repeat (3)
		begin
			check_flag("mu_busy while the update closes", mu_busy, 1'b1);
			@(negedge clk);
		end
		// Swap on the third edge
		check_flag("mu_busy after the swap", mu_busy, 1'b0);
	endtask

	// Returns once the request is sure to transfer on the next edge
	task automatic send_req(input logic [MAX_ADDR_W-1:0] a, input logic [MAX_ADDR_W-1:0] b);
		int waited;
		waited = 0;
		@(posedge clk);
		req <= '{addr_a: a, addr_b: b};
		req_valid <= 1'b1;
		@(negedge clk);
		while (!req_ready)
		begin
			waited++;
			if (waited > WAIT_LIMIT)
				stop_with_error("request was never accepted");
			@(negedge clk);
		end
	endtask

	// Withdraw valid on the transfer edge of the last request
	task automatic drop_req();
		if (req_valid)
		begin
			@(posedge clk);
			req_valid <= 1'b0;
		end
	endtask

	task automatic check_result(input pos_t exp_a, input pos_t exp_b, input dist2_t exp_dist);
		pair_res_t r;
		int        waited;
		waited = 0;
		while (got_q.size() == 0)
		begin
			waited++;
			if (waited > WAIT_LIMIT)
				stop_with_error("no pair result arrived");
			@(negedge clk);
		end
		r = got_q.pop_front();
		check_pos("pos_a", r.pos_a, exp_a);
		check_pos("pos_b", r.pos_b, exp_b);
		check_dist("dist2", r.dist2, exp_dist);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Record loop
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		mu_enable = 1'b0;
		bcast = '0;
		req = '0;
		req_valid = 1'b0;
		done = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("mu_busy after reset", mu_busy, 1'b0);
		check_flag("req_ready after reset", req_ready, 1'b1);
		fd = $fopen("dv/cell_pair_input.txt", "r");
		if (fd == 0)
			stop_with_error("cannot open dv/cell_pair_input.txt");
		while (!done)
		begin
			tag = '0;
			n = $fscanf(fd, "%s", tag);
			if (n != 1)
				done = 1'b1;
			else if (tag == "R")
			begin
				n = $fscanf(fd, "%h %h", addr_a, addr_b);
				if (n != 2)
					stop_with_error("malformed request record");
				clear_bus();
				// Back-to-back requests keep valid high
				send_req(addr_a, addr_b);
			end
			else
			begin
				// Particles stay on the bus only across consecutive broadcasts
				if (tag != "B")
					clear_bus();
				drop_req();
				case (tag)
					"#":
					begin
						n = $fgets(line, fd);
					end
					"B":
					begin
						n = $fscanf(fd, "%h %h %h %h", dst, fld[0], fld[1], fld[2]);
						if (n != 4)
							stop_with_error("malformed broadcast record");
						send_particle(dst, '{z: fld[2], y: fld[1], x: fld[0]});
					end
					"E":
					begin
						end_update();
					end
					"X":
					begin
						n = $fscanf(fd, "%h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
							fld[3], fld[4], fld[5], exp_d);
						if (n != 7)
							stop_with_error("malformed expected-result record");
						check_result('{z: fld[2], y: fld[1], x: fld[0]},
							'{z: fld[5], y: fld[4], x: fld[3]}, exp_d);
					end
					"S":
					begin
						n = $fscanf(fd, "%d", gap_in);
						if (n != 1)
							stop_with_error("malformed stall record");
						max_gap <= gap_in;
					end
					default:
					begin
						stop_with_error("unknown record type in input file");
					end
				endcase
			end
		end
		$fclose(fd);
		clear_bus();
		drop_req();
		// Quiet period, a stray result would land in the queue
		repeat (8) @(negedge clk);
		if (got_q.size() != 0)
			stop_with_error("more results than expected");
		if (u_cell_pair_top.u_pair.u_checks.fail_cnt == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("TESTS FAILED");
			$fatal(1, "Assertions failed during the run");
		end
	end

endmodule

// ==== hdl/cell_pair_top.sv ====
// Two-cell slice top level
// Position caches for cells A and B feeding one pair unit

`timescale 1ns/1ps

module cell_pair_top #(
	parameter int                    DEPTH  = 64,
	parameter md_geom_pkg::cell_id_t CELL_A = '{cx: 4'd0, cy: 4'd0, cz: 4'd0},
	parameter md_geom_pkg::cell_id_t CELL_B = '{cx: 4'd0, cy: 4'd0, cz: 4'd1}
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mu_enable,
	input  md_ctrl_pkg::bcast_t    bcast,
	input  md_ctrl_pkg::pair_req_t req,
	input  logic                   req_valid,
	output logic                   req_ready,
	output md_ctrl_pkg::pair_res_t res,
	output logic                   res_valid,
	input  logic                   res_ready,
	output logic                   mu_busy
);

	import md_geom_pkg::*;
	import md_ctrl_pkg::*;

	// Read ports and readouts between the pair unit and the caches
	cache_rd_t rd_a;
	cache_rd_t rd_b;
	pos_t      q_a;
	pos_t      q_b;

	//////////////////////////////////////////////////////////////////////
	// Cell caches
	//////////////////////////////////////////////////////////////////////

	// Both caches see the whole broadcast and keep their own particles
	pos_cache #(
		.DEPTH   (DEPTH),
		.MY_CELL (CELL_A)
	) u_cache_a (
		.clk       (clk),
		.rst       (rst),
		.mu_enable (mu_enable),
		.bcast     (bcast),
		.rd        (rd_a),
		.q         (q_a),
		.busy      (mu_busy)
	);

	// Runs in lockstep with cache A, so its busy flag is not needed
	pos_cache #(
		.DEPTH   (DEPTH),
		.MY_CELL (CELL_B)
	) u_cache_b (
		.clk       (clk),
		.rst       (rst),
		.mu_enable (mu_enable),
		.bcast     (bcast),
		.rd        (rd_b),
		.q         (q_b),
		.busy      ()
	);

	//////////////////////////////////////////////////////////////////////
	// Pair unit
	//////////////////////////////////////////////////////////////////////

	pair_dist u_pair (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.q_a       (q_a),
		.q_b       (q_b),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

endmodule

// ==== hdl/md_ctrl_pkg.sv ====
// Control structs for the cache slice
// Broadcast bus, pair request, cache read port and pair result

package md_ctrl_pkg;

	// Widest read address a request can carry
	parameter int MAX_ADDR_W = 8;

	//////////////////////////////////////////////////////////////////////
	// Motion update bus
	//////////////////////////////////////////////////////////////////////

	// One particle per cycle, tagged with the cell it moves into
	typedef struct packed {
		logic                  valid;
		md_geom_pkg::cell_id_t dst;
		md_geom_pkg::pos_t     pos;
	} bcast_t;

	//////////////////////////////////////////////////////////////////////
	// Pair lookup
	//////////////////////////////////////////////////////////////////////

	// Word addresses into cell A and cell B
	// Narrow caches use only the low bits
	typedef struct packed {
		logic [MAX_ADDR_W-1:0] addr_a;
		logic [MAX_ADDR_W-1:0] addr_b;
	} pair_req_t;

	// Read port into one cache
	typedef struct packed {
		logic                  en;
		logic [MAX_ADDR_W-1:0] addr;
	} cache_rd_t;

	// Both positions and their squared distance
	typedef struct packed {
		md_geom_pkg::pos_t   pos_a;
		md_geom_pkg::pos_t   pos_b;
		md_geom_pkg::dist2_t dist2;
	} pair_res_t;

endpackage

// ==== hdl/md_geom_pkg.sv ====
// Geometry types for the position caches
// Coordinates, packed positions, cell identifiers and squared distances

package md_geom_pkg;

	//////////////////////////////////////////////////////////////////////
	// Coordinate format
	//////////////////////////////////////////////////////////////////////

	// Width of one signed fixed-point coordinate
	parameter int COORD_W = 16;

	// One axis of a particle position
	typedef logic signed [COORD_W-1:0] coord_t;

	// Particle position, z in the top bits and x in the bottom bits
	// Word 0 of every buffer keeps the particle count in x
	typedef struct packed {
		coord_t z;
		coord_t y;
		coord_t x;
	} pos_t;

	//////////////////////////////////////////////////////////////////////
	// Cell addressing
	//////////////////////////////////////////////////////////////////////

	// Cell identity, cx in the top bits
	typedef struct packed {
		logic [3:0] cx;
		logic [3:0] cy;
		logic [3:0] cz;
	} cell_id_t;

	//////////////////////////////////////////////////////////////////////
	// Pair distance
	//////////////////////////////////////////////////////////////////////

	// Sum of three squared 17-bit differences, always non-negative
	typedef logic [2*COORD_W+2:0] dist2_t;

endpackage

// ==== hdl/pair_dist.sv ====
// Pair lookup pipeline across two caches
// Read issue stage and squared-distance result stage with back-pressure

`timescale 1ns/1ps

module pair_dist (
	input  logic                   clk,
	input  logic                   rst,
	input  md_ctrl_pkg::pair_req_t req,
	input  logic                   req_valid,
	output logic                   req_ready,
	output md_ctrl_pkg::cache_rd_t rd_a,
	output md_ctrl_pkg::cache_rd_t rd_b,
	input  md_geom_pkg::pos_t      q_a,
	input  md_geom_pkg::pos_t      q_b,
	output md_ctrl_pkg::pair_res_t res,
	output logic                   res_valid,
	input  logic                   res_ready
);

	import md_geom_pkg::*;

	// Result held and not taken
	logic stall;
	// Request accepted this cycle
	logic issue;
	// Cache readouts carry a live request
	logic s1_valid;
	// Per-axis differences, one bit wider than a coordinate
	logic signed [COORD_W:0] dx;
	logic signed [COORD_W:0] dy;
	logic signed [COORD_W:0] dz;
	dist2_t sq_x;
	dist2_t sq_y;
	dist2_t sq_z;
	dist2_t sum;

	//////////////////////////////////////////////////////////////////////
	// Issue stage
	//////////////////////////////////////////////////////////////////////

	// Whole pipeline freezes behind a held result
	assign stall = res_valid && !res_ready;
	assign req_ready = !stall;
	assign issue = req_valid && req_ready;

	// Same-cycle read into both cells
	// Enables drop on stall so the cache readouts hold
	assign rd_a = '{en: issue, addr: req.addr_a};
	assign rd_b = '{en: issue, addr: req.addr_b};

	//////////////////////////////////////////////////////////////////////
	// Distance stage
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		dx = q_a.x - q_b.x;
		dy = q_a.y - q_b.y;
		dz = q_a.z - q_b.z;
		// Signed squares are never negative
		sq_x = dx * dx;
		sq_y = dy * dy;
		sq_z = dz * dz;
		sum = sq_x + sq_y + sq_z;
	end

	// Valid bits advance together unless stalled
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
		end
		else if (!stall)
		begin
			s1_valid <= issue;
			res_valid <= s1_valid;
		end
	end

	// Result register, stable until taken
	always_ff @(posedge clk)
	begin
		if (!stall && s1_valid)
		begin
			res <= '{pos_a: q_a, pos_b: q_b, dist2: sum};
		end
	end

endmodule

// ==== hdl/pos_cache.sv ====
// Double-buffered position cache for one cell
// Motion update FSM, two buffer memories and the readout mux

`timescale 1ns/1ps

module pos_cache #(
	parameter int                    DEPTH   = 64,
	parameter md_geom_pkg::cell_id_t MY_CELL = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mu_enable,
	input  md_ctrl_pkg::bcast_t    bcast,
	input  md_ctrl_pkg::cache_rd_t rd,
	output md_geom_pkg::pos_t      q,
	output logic                   busy
);

	import md_geom_pkg::*;

	// Word address width inside one buffer
	localparam int ADDR_W = $clog2(DEPTH);
	// Counter must reach DEPTH to flag a full buffer
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

	//////////////////////////////////////////////////////////////////////
	// Motion update FSM
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		S_IDLE,
		S_COLLECT,
		S_WR_COUNT,
		S_SWAP
	} state_t;

	state_t            state;
	// Buffer currently serving reads
	logic              active;
	// Next free shadow address, also count plus one
	logic [CNT_W-1:0]  cnt;
	// Registered shadow write, lands one edge after capture
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	pos_t              wr_data;
	logic              hit;
	logic              room;
	logic              take;
	logic              end_upd;
	pos_t              count_word;
	// Buffer that owns the word in flight on the read port
	logic              rd_sel;

	// Particle addressed to this cell
	assign hit = bcast.valid && (bcast.dst == MY_CELL);
	// Words past DEPTH-1 are dropped
	assign room = (cnt != CNT_FULL);

	// Keep the particle on any edge of the update where it fits
	assign take = mu_enable && hit && room &&
		((state == S_IDLE) || (state == S_COLLECT));

	// First edge with mu_enable low
	assign end_upd = (state == S_COLLECT) && !mu_enable;

	// Count word, zero-extended into x
	always_comb
	begin
		count_word = '0;
		count_word.x = COORD_W'(cnt - 1'b1);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			active <= 1'b0;
			cnt <= CNT_W'(1);
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= take || end_upd;
			if (take)
			begin
				cnt <= cnt + 1'b1;
			end
			case (state)
				S_IDLE:
				begin
					// First broadcast may arrive on the start edge
					if (mu_enable)
					begin
						state <= S_COLLECT;
					end
				end
				S_COLLECT:
				begin
					if (!mu_enable)
					begin
						state <= S_WR_COUNT;
					end
				end
				// Count word is written on the way out of this state
				S_WR_COUNT:
				begin
					state <= S_SWAP;
				end
				S_SWAP:
				begin
					active <= ~active;
					// Address 0 stays reserved for the count
					cnt <= CNT_W'(1);
					state <= S_IDLE;
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Shadow write payload
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			wr_addr <= cnt[ADDR_W-1:0];
			wr_data <= bcast.pos;
		end
		else if (end_upd)
		begin
			wr_addr <= '0;
			wr_data <= count_word;
		end
	end

	assign busy = (state != S_IDLE);

	//////////////////////////////////////////////////////////////////////
	// Buffer memories
	//////////////////////////////////////////////////////////////////////

	// Two single-port buffers, one serves reads and one takes writes
	for (genvar b = 0; b < 2; b++)
	begin : g_buf
		localparam logic SEL = 1'(b);

		pos_t              mem [DEPTH];
		pos_t              q_r;
		logic              is_active;
		logic              we;
		logic              re;
		logic [ADDR_W-1:0] addr;

		assign is_active = (active == SEL);
		assign we = wr_en && !is_active;
		assign re = rd.en && is_active;
		// Single address port shared by reader and writer
		assign addr = is_active ? rd.addr[ADDR_W-1:0] : wr_addr;

		// Both buffers power up empty
		initial
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				mem[i] = '0;
			end
			q_r = '0;
		end

		// Readout holds while the enable is low
		always @(posedge clk)
		begin
			if (we)
			begin
				mem[addr] <= wr_data;
			end
			if (re)
			begin
				q_r <= mem[addr];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readout mux
	//////////////////////////////////////////////////////////////////////

	// Follow the buffer that was read, not the one active now
	// A read on the swap edge still returns the old buffer
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_sel <= 1'b0;
		end
		else if (rd.en)
		begin
			rd_sel <= active;
		end
	end

	assign q = rd_sel ? g_buf[1].q_r : g_buf[0].q_r;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cell_pair_tb \
	-f verilog.f -Mdir obj_dir -o cell_pair_sim || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/cell_pair_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TESTS PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }

// ==== verilog.f ====
hdl/md_geom_pkg.sv
hdl/md_ctrl_pkg.sv
hdl/pos_cache.sv
hdl/pair_dist.sv
hdl/cell_pair_top.sv
dv/cell_pair_assertions.sv
dv/cell_pair_tb.sv
